/* Makefile */
# Verilator build and run for the power-gated register-file array

VERILATOR ?= verilator
TOP       ?= rf_pg_array_tb
FILELIST  ?= rf_pg_array.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run the testbench and pass its exit status on to make
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* logic/rf_bank_8x21.sv */
// Power-gated 8x21 storage bank with power-good chain, clear on power down and read isolation
module rf_bank_8x21 (

     input  logic                                   wclk
    ,input  logic                                   rclk
    ,input  logic                                   arst_n

    // Write port in the wclk domain
    ,input  logic                                   we
    ,input  logic [rf_geom_pkg::WORD_ADDR_W-1:0]    waddr
    ,input  logic [rf_geom_pkg::DATA_W-1:0]         wdata

    // Combinational read port
    ,input  logic [rf_geom_pkg::WORD_ADDR_W-1:0]    raddr
    ,output logic [rf_geom_pkg::DATA_W-1:0]         rdata

    // Power interface
    ,input  rf_pwr_pkg::pwr_ctl_t                   pwr
    ,output logic                                   pwr_enable_b_out
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // One flop row per word
    logic [rf_geom_pkg::DATA_W-1:0] mem [rf_geom_pkg::BANK_DEPTH];

    // Delayed copy of the switch enable standing in for the switch chain
    logic [rf_pwr_pkg::WAKE_CYCLES-1:0] pg_chain;

    // Contents start at zero out of reset
    // While the switch enable is high the bank has no supply
    // so every word collapses to zero and writes have nowhere to land
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rf_geom_pkg::BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (pwr.pwr_enable_b) begin
            for (int i = 0; i < rf_geom_pkg::BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Power-good chain
    // ------------------------------------------------------------------------

    // The enable ripples through the switch segments one rclk per stage
    // Out of reset the bank is powered so every stage starts low
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            pg_chain <= '0;
        end else begin
            pg_chain <= {pg_chain[rf_pwr_pkg::WAKE_CYCLES-2:0], pwr.pwr_enable_b};
        end
    end

    // Last segment reports back to the sequencer
    assign pwr_enable_b_out = pg_chain[rf_pwr_pkg::WAKE_CYCLES-1];

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    // Isolation clamps the output so a bank in transition never drives
    // stray values into the read mux
    always_comb begin
        if (pwr.isol_en) begin
            rdata = '0;
        end else begin
            rdata = mem[raddr];
        end
    end

endmodule

/* logic/rf_geom_pkg.sv */
// Array geometry, address split and write-port bundle for the register-file array
package rf_geom_pkg;

    // ------------------------------------------------------------------------
    // Array dimensions
    // ------------------------------------------------------------------------

    // Four independently power-gated banks
    localparam int NUM_BANKS   = 4;

    // Each bank is a small 8 entry register file
    localparam int BANK_DEPTH  = 8;

    // Word select inside one bank
    localparam int WORD_ADDR_W = 3;

    // Bank select taken from the upper address bits
    localparam int BANK_SEL_W  = 2;

    // Payload width of one stored word
    localparam int DATA_W      = 21;

    // Saturating count of writes lost to sleeping banks
    localparam int DROP_CNT_W  = 16;

    // ------------------------------------------------------------------------
    // Address and write-port bundles
    // ------------------------------------------------------------------------

    // Full 5 bit word address with the bank number in the upper bits
    typedef struct packed {
        logic [BANK_SEL_W-1:0]  bank;
        logic [WORD_ADDR_W-1:0] word;
    } rf_addr_t;

    // One write request as it arrives on the wclk side
    typedef struct packed {
        logic                   en;
        rf_addr_t               addr;
        logic [DATA_W-1:0]      data;
    } rf_wr_t;

endpackage

/* logic/rf_pg_array.sv */
// Top level of the power-gated register file, joining steer, sequencer, banks and read select
module rf_pg_array (

     input  logic                                   wclk
    ,input  logic                                   rclk
    ,input  logic                                   arst_n

    // Write port in the wclk domain
    ,input  logic                                   we
    ,input  rf_geom_pkg::rf_addr_t                  wr_addr
    ,input  logic [rf_geom_pkg::DATA_W-1:0]         wr_data

    // Read port in the rclk domain
    ,input  logic                                   re
    ,input  rf_geom_pkg::rf_addr_t                  rd_addr
    ,output logic [rf_geom_pkg::DATA_W-1:0]         rdata

    // Power requests and status
    ,input  logic [rf_geom_pkg::NUM_BANKS-1:0]      bank_sleep
    ,output logic [rf_geom_pkg::NUM_BANKS-1:0]      ready
    ,output logic [rf_geom_pkg::DROP_CNT_W-1:0]     drop_count
);

    // ------------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------------

    rf_geom_pkg::rf_wr_t                               wr_req;
    logic [rf_geom_pkg::NUM_BANKS-1:0]                 bank_we;
    logic [rf_geom_pkg::WORD_ADDR_W-1:0]               bank_waddr;
    logic [rf_geom_pkg::DATA_W-1:0]                    bank_wdata;
    logic [rf_geom_pkg::NUM_BANKS-1:0][rf_geom_pkg::DATA_W-1:0] bank_rdata;
    rf_pwr_pkg::pwr_ctl_t [rf_geom_pkg::NUM_BANKS-1:0] pwr_ctl;
    logic [rf_geom_pkg::NUM_BANKS-1:0]                 pg_out;

    // Gather the write pins into one request
    assign wr_req = '{en: we, addr: wr_addr, data: wr_data};

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------

    rf_write_steer i_steer (
         .wclk          (wclk)
        ,.arst_n        (arst_n)
        ,.wr            (wr_req)
        ,.ready         (ready)
        ,.bank_we       (bank_we)
        ,.bank_waddr    (bank_waddr)
        ,.bank_wdata    (bank_wdata)
        ,.drop_count    (drop_count)
    );

    // ------------------------------------------------------------------------
    // Power sequencing
    // ------------------------------------------------------------------------

    rf_pwr_seq i_seq (
         .rclk              (rclk)
        ,.arst_n            (arst_n)
        ,.bank_sleep        (bank_sleep)
        ,.pwr_enable_b_out  (pg_out)
        ,.pwr               (pwr_ctl)
        ,.ready             (ready)
    );

    // ------------------------------------------------------------------------
    // Banks
    // ------------------------------------------------------------------------

    // Every bank sees the same word address on both ports
    for (genvar b = 0; b < rf_geom_pkg::NUM_BANKS; b++) begin : g_bank
        rf_bank_8x21 i_bank (
             .wclk              (wclk)
            ,.rclk              (rclk)
            ,.arst_n            (arst_n)
            ,.we                (bank_we[b])
            ,.waddr             (bank_waddr)
            ,.wdata             (bank_wdata)
            ,.raddr             (rd_addr.word)
            ,.rdata             (bank_rdata[b])
            ,.pwr               (pwr_ctl[b])
            ,.pwr_enable_b_out  (pg_out[b])
        );
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------

    rf_read_select i_rsel (
         .rclk          (rclk)
        ,.arst_n        (arst_n)
        ,.re            (re)
        ,.bank          (rd_addr.bank)
        ,.bank_rdata    (bank_rdata)
        ,.rdata         (rdata)
    );

endmodule

/* logic/rf_pwr_pkg.sv */
// Power sequencing states, wake delay and per-bank power controls for the array
package rf_pwr_pkg;

    // ------------------------------------------------------------------------
    // Power switch model
    // ------------------------------------------------------------------------

    // Depth of the power-good chain in each bank, counted in rclk cycles
    localparam int WAKE_CYCLES  = 4;

    // Encoding width of the sequencer state
    localparam int PWR_STATE_W  = 3;

    // ------------------------------------------------------------------------
    // Sequencer state and bank controls
    // ------------------------------------------------------------------------

    // Steady on, entering sleep, asleep, waiting for power good, leaving isolation
    typedef enum logic [PWR_STATE_W-1:0] {
        PWR_ON    = 3'd0,
        PWR_ISO   = 3'd1,
        PWR_OFF   = 3'd2,
        PWR_WAKE  = 3'd3,
        PWR_UNISO = 3'd4
    } pwr_state_t;

    // Controls driven from the sequencer into one bank
    // Both bits low means powered and visible
    typedef struct packed {
        // Clamp the bank read data to zero
        logic isol_en;
        // Active low switch enable so a high value removes bank power
        logic pwr_enable_b;
    } pwr_ctl_t;

endpackage

/* logic/rf_pwr_seq.sv */
// Power sequencer for the array top, one FSM per bank ordering isolation, power and wake
module rf_pwr_seq (

     input  logic                                   rclk
    ,input  logic                                   arst_n

    // Level requests where a high bit asks that bank to sleep
    ,input  logic [rf_geom_pkg::NUM_BANKS-1:0]      bank_sleep

    // Power-good feedback from each bank switch chain
    ,input  logic [rf_geom_pkg::NUM_BANKS-1:0]      pwr_enable_b_out

    // Controls into the banks
    ,output rf_pwr_pkg::pwr_ctl_t [rf_geom_pkg::NUM_BANKS-1:0] pwr

    // High while the bank holds valid data and accepts traffic
    ,output logic [rf_geom_pkg::NUM_BANKS-1:0]      ready
);

    // ------------------------------------------------------------------------
    // One state machine per bank
    // ------------------------------------------------------------------------

    for (genvar b = 0; b < rf_geom_pkg::NUM_BANKS; b++) begin : g_seq

        rf_pwr_pkg::pwr_state_t state_q;
        rf_pwr_pkg::pwr_state_t state_d;

        // Going down is isolate then cut power
        // Coming up is restore power, wait for the chain, then open isolation
        always_comb begin
            state_d = state_q;
            case (state_q)
                rf_pwr_pkg::PWR_ON: begin
                    if (bank_sleep[b]) begin
                        state_d = rf_pwr_pkg::PWR_ISO;
                    end
                end
                // Outputs are clamped for a full cycle before power goes away
                rf_pwr_pkg::PWR_ISO: begin
                    state_d = rf_pwr_pkg::PWR_OFF;
                end
                rf_pwr_pkg::PWR_OFF: begin
                    if (!bank_sleep[b]) begin
                        state_d = rf_pwr_pkg::PWR_WAKE;
                    end
                end
                // No counter here since the bank itself says when it is powered
                rf_pwr_pkg::PWR_WAKE: begin
                    if (!pwr_enable_b_out[b]) begin
                        state_d = rf_pwr_pkg::PWR_UNISO;
                    end
                end
                // Power is good and the clamp is lifted on the way to ON
                rf_pwr_pkg::PWR_UNISO: begin
                    state_d = rf_pwr_pkg::PWR_ON;
                end
                default: begin
                    state_d = rf_pwr_pkg::PWR_ON;
                end
            endcase
        end

        // All banks start awake
        always_ff @(posedge rclk or negedge arst_n) begin
            if (!arst_n) begin
                state_q <= rf_pwr_pkg::PWR_ON;
            end else begin
                state_q <= state_d;
            end
        end

        // Isolation covers every state except steady on, so it drops
        // in the same cycle that ready rises
        // The switch is open only while fully asleep
        assign pwr[b] = rf_pwr_pkg::pwr_ctl_t'{
            isol_en:      (state_q != rf_pwr_pkg::PWR_ON),
            pwr_enable_b: (state_q == rf_pwr_pkg::PWR_OFF)
        };

        assign ready[b] = (state_q == rf_pwr_pkg::PWR_ON);

    end

endmodule

/* logic/rf_read_select.sv */
// Read-side output register that captures the addressed bank word on each read strobe
module rf_read_select (

     input  logic                                   rclk
    ,input  logic                                   arst_n

    // Read strobe and the bank part of the read address
    ,input  logic                                   re
    ,input  logic [rf_geom_pkg::BANK_SEL_W-1:0]     bank

    // Combinational words presented by all banks
    ,input  logic [rf_geom_pkg::NUM_BANKS-1:0][rf_geom_pkg::DATA_W-1:0] bank_rdata

    // Held read result
    ,output logic [rf_geom_pkg::DATA_W-1:0]         rdata
);

    // ------------------------------------------------------------------------
    // Bank mux
    // ------------------------------------------------------------------------

    logic [rf_geom_pkg::DATA_W-1:0] sel_word;

    // Every bank already looks at the word address so only the bank
    // number is left to resolve here
    // Isolated banks present zero which passes straight through
    assign sel_word = bank_rdata[bank];

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    // One cycle read latency
    // The register keeps its value between strobes so the last result
    // stays visible until the next read
    always_ff @(posedge rclk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= sel_word;
        end
    end

endmodule

/* logic/rf_write_steer.sv */
// Write-side steering that routes each write to one ready bank and counts dropped writes
module rf_write_steer (

     input  logic                                   wclk
    ,input  logic                                   arst_n

    // Incoming write request
    ,input  rf_geom_pkg::rf_wr_t                    wr

    // Bank readiness from the rclk sequencer
    ,input  logic [rf_geom_pkg::NUM_BANKS-1:0]      ready

    // Shared write bus towards the banks
    ,output logic [rf_geom_pkg::NUM_BANKS-1:0]      bank_we
    ,output logic [rf_geom_pkg::WORD_ADDR_W-1:0]    bank_waddr
    ,output logic [rf_geom_pkg::DATA_W-1:0]         bank_wdata

    ,output logic [rf_geom_pkg::DROP_CNT_W-1:0]     drop_count
);

    // ------------------------------------------------------------------------
    // Readiness synchronizer
    // ------------------------------------------------------------------------

    logic [rf_geom_pkg::NUM_BANKS-1:0] ready_meta;
    logic [rf_geom_pkg::NUM_BANKS-1:0] ready_wclk;
    logic                              wr_drop;

    // Two flops per bank
    // All banks come out of reset powered so both stages start high
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            ready_meta <= '1;
            ready_wclk <= '1;
        end else begin
            ready_meta <= ready;
            ready_wclk <= ready_meta;
        end
    end

    // ------------------------------------------------------------------------
    // Steering
    // ------------------------------------------------------------------------

    // Word and data fan out to every bank and only the enable is decoded
    assign bank_waddr = wr.addr.word;
    assign bank_wdata = wr.data;

    always_comb begin
        bank_we = '0;
        if (wr.en && ready_wclk[wr.addr.bank]) begin
            bank_we[wr.addr.bank] = 1'b1;
        end
    end

    // A write aimed at a bank that is not ready in wclk is lost
    assign wr_drop = wr.en && !ready_wclk[wr.addr.bank];

    // Counter sticks at all ones instead of wrapping
    always_ff @(posedge wclk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= '0;
        end else if (wr_drop && (drop_count != '1)) begin
            drop_count <= drop_count + rf_geom_pkg::DROP_CNT_W'(1);
        end
    end

endmodule

/* rf_pg_array.f */
logic/rf_geom_pkg.sv
logic/rf_pwr_pkg.sv
logic/rf_bank_8x21.sv
logic/rf_write_steer.sv
logic/rf_read_select.sv
logic/rf_pwr_seq.sv
logic/rf_pg_array.sv
test/rf_pg_array_tb.sv

/* test/rf_pg_array_tb.sv */
// Simulation top that drives LCG traffic into the power-gated array and checks it against a model
module rf_pg_array_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // Constants and signals
    // ------------------------------------------------------------------------

    localparam int CLK_HALF      = 10;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int WAIT_LIMIT    = 50;
    localparam int SETTLE_CYCLES = 4;
    localparam int RANDOM_STEPS  = 300;
    localparam int MIX_STEPS     = 2000;
    localparam int NUM_WORDS     = rf_geom_pkg::NUM_BANKS * rf_geom_pkg::BANK_DEPTH;

    logic                                   wclk;
    logic                                   rclk;
    logic                                   arst_n;
    logic                                   we;
    rf_geom_pkg::rf_addr_t                  wr_addr;
    logic [rf_geom_pkg::DATA_W-1:0]         wr_data;
    logic                                   re;
    rf_geom_pkg::rf_addr_t                  rd_addr;
    logic [rf_geom_pkg::DATA_W-1:0]         rdata;
    logic [rf_geom_pkg::NUM_BANKS-1:0]      bank_sleep;
    logic [rf_geom_pkg::NUM_BANKS-1:0]      ready;
    logic [rf_geom_pkg::DROP_CNT_W-1:0]     drop_count;

    // Reference model of the array contents, bank power and lost writes
    logic [rf_geom_pkg::DATA_W-1:0]         model_mem [NUM_WORDS];
    logic [rf_geom_pkg::NUM_BANKS-1:0]      model_awake;
    logic [rf_geom_pkg::DROP_CNT_W-1:0]     model_drops;
    // Held read result, which only changes on a read strobe
    logic [rf_geom_pkg::DATA_W-1:0]         model_rdata;
    logic [31:0]                            lcg_state;

    rf_pg_array dut0 (
         .wclk          (wclk)
        ,.rclk          (rclk)
        ,.arst_n        (arst_n)
        ,.we            (we)
        ,.wr_addr       (wr_addr)
        ,.wr_data       (wr_data)
        ,.re            (re)
        ,.rd_addr       (rd_addr)
        ,.rdata         (rdata)
        ,.bank_sleep    (bank_sleep)
        ,.ready         (ready)
        ,.drop_count    (drop_count)
    );

    // Both domains toggle together so the clocks stay in phase
    initial begin
        wclk = 1'b0;
        rclk = 1'b0;
        forever begin
            #CLK_HALF;
            wclk = ~wclk;
            rclk = ~rclk;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits are used since the low bits repeat quickly
    function rf_geom_pkg::rf_addr_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return rf_geom_pkg::rf_addr_t'(r[20:16]);
    endfunction

    function logic [rf_geom_pkg::DATA_W-1:0] rand_data();
        logic [31:0] r;
        r = next_rand();
        return r[30:10];
    endfunction

    function int word_index(input rf_geom_pkg::rf_addr_t a);
        return int'({a.bank, a.word});
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // One clock of traffic; the read sees the array before this cycle's write
    task automatic step(input logic do_wr, input rf_geom_pkg::rf_addr_t waddr,
                        input logic [rf_geom_pkg::DATA_W-1:0] wdata,
                        input logic do_rd, input rf_geom_pkg::rf_addr_t raddr);
        we      = do_wr;
        wr_addr = waddr;
        wr_data = wdata;
        re      = do_rd;
        rd_addr = raddr;
        // A sleeping bank is isolated and its contents are already gone
        if (do_rd) begin
            model_rdata = model_awake[raddr.bank] ? model_mem[word_index(raddr)] : '0;
        end
        if (do_wr) begin
            if (model_awake[waddr.bank]) begin
                model_mem[word_index(waddr)] = wdata;
            end else begin
                model_drops = model_drops + 1'b1;
            end
        end
        @(posedge rclk);
        #DRIVE_DELAY;
        check_value("rdata", 32'(rdata), 32'(model_rdata));
        check_value("drop_count", 32'(drop_count), 32'(model_drops));
    endtask

    task automatic idle_step();
        step(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic read_all();
        for (int a = 0; a < NUM_WORDS; a++) begin
            step(1'b0, '0, '0, 1'b1, rf_geom_pkg::rf_addr_t'(a));
        end
    endtask

    task automatic sleep_bank(input int b);
        int waited;
        bank_sleep[b] = 1'b1;
        model_awake[b] = 1'b0;
        for (int w = 0; w < rf_geom_pkg::BANK_DEPTH; w++) begin
            model_mem[b * rf_geom_pkg::BANK_DEPTH + w] = '0;
        end
        waited = 0;
        while (ready[b]) begin
            if (waited == WAIT_LIMIT) begin
                $display("Bank %0d did not drop ready within %0d cycles of a sleep request",
                         b, WAIT_LIMIT);
                $display("Verification failed");
                $fatal(1, "sleep timeout");
            end
            idle_step();
            waited++;
        end
        // Let the write-side synchronizer catch up before more traffic
        repeat (SETTLE_CYCLES) idle_step();
    endtask

    task automatic wake_bank(input int b);
        int waited;
        bank_sleep[b] = 1'b0;
        waited = 0;
        while (!ready[b]) begin
            if (waited == WAIT_LIMIT) begin
                $display("Bank %0d did not raise ready within %0d cycles of a wake request",
                         b, WAIT_LIMIT);
                $display("Verification failed");
                $fatal(1, "wake timeout");
            end
            idle_step();
            waited++;
        end
        model_awake[b] = 1'b1;
        repeat (SETTLE_CYCLES) idle_step();
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [31:0] r;
        int          sb;
        rf_geom_pkg::rf_addr_t a;

        lcg_state   = 32'd26;
        arst_n      = 1'b0;
        we          = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        re          = 1'b0;
        rd_addr     = '0;
        bank_sleep  = '0;
        model_awake = '1;
        model_drops = '0;
        model_rdata = '0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge rclk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        // Reset state
        check_value("ready", 32'(ready), 32'hF);
        check_value("drop_count", 32'(drop_count), 32'h0);
        read_all();

        // Random traffic with every bank awake
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            r = next_rand();
            step(r[28], rand_addr(), rand_data(), r[29], rand_addr());
        end
        read_all();

        // Put one bank to sleep, then read and write it while it is down
        r  = next_rand();
        sb = int'(r[17:16]);
        sleep_bank(sb);
        for (int w = 0; w < rf_geom_pkg::BANK_DEPTH; w++) begin
            a = '{bank: sb[1:0], word: w[2:0]};
            step(1'b1, a, rand_data(), 1'b1, a);
        end
        read_all();

        // Wake it, confirm it came back empty, then refill it
        wake_bank(sb);
        read_all();
        for (int w = 0; w < rf_geom_pkg::BANK_DEPTH; w++) begin
            a = '{bank: sb[1:0], word: w[2:0]};
            step(1'b1, a, rand_data(), 1'b0, '0);
        end
        read_all();

        // Long mix with occasional power toggles on random banks
        for (int i = 0; i < MIX_STEPS; i++) begin
            r = next_rand();
            if (r[31:26] == 6'd0) begin
                sb = int'(r[17:16]);
                if (model_awake[sb]) begin
                    sleep_bank(sb);
                end else begin
                    wake_bank(sb);
                end
            end else begin
                step(r[28], rand_addr(), rand_data(), r[29], rand_addr());
            end
        end

        // Bring everything back up and sweep the whole array once more
        for (int b = 0; b < rf_geom_pkg::NUM_BANKS; b++) begin
            if (!model_awake[b]) begin
                wake_bank(b);
            end
        end
        read_all();

        $display("Verification passed");
        $finish;
    end

endmodule
